//--- run.sh
#!/bin/sh
# build and run the lookup engine testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_lookup_engine > sim.log 2>&1 \
    && ./obj_dir/Vtb_lookup_engine >> sim.log 2>&1 \
    || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

//--- src/action_ram.sv
`timescale 1ns/1ps

module action_ram (
    input  logic                              clk,
    table_wr_if.act                           wr,
    input  logic [lookup_pkg::tbl_addr_w-1:0] match_addr,
    output logic [lookup_pkg::act_w-1:0]      action_rdata
);

    logic [lookup_pkg::act_w-1:0]      mem [lookup_pkg::tbl_depth];
    logic [lookup_pkg::tbl_addr_w-1:0] rd_addr;

    always_ff @(posedge clk) begin
        if (wr.act_we) begin
            mem[wr.act_addr] <= wr.act_data;
        end
    end

    // registered address then output register, like a block ram
    always_ff @(posedge clk) begin
        rd_addr      <= match_addr;
        action_rdata <= mem[rd_addr];
    end

endmodule

//--- src/ctrl_parser.sv
`timescale 1ns/1ps

module ctrl_parser (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [lookup_pkg::cdata_w-1:0] c_s_tdata,
    input  logic                           c_s_tvalid,
    input  logic                           c_s_tlast,
    output logic [lookup_pkg::cdata_w-1:0] c_m_tdata,
    output logic                           c_m_tvalid,
    output logic                           c_m_tlast,
    table_wr_if.master                     wr
);

    lookup_pkg::ctrl_beat_u            beat;
    logic [lookup_pkg::cdata_w-1:0]    swapped;
    logic                              hdr_hit;
    logic [1:0]                        state;
    logic [lookup_pkg::tbl_addr_w-1:0] index;

    assign beat = c_s_tdata;

    // header addressed to this stage and lookup
    assign hdr_hit = (beat.hdr.mod_id == {lookup_pkg::stage_id, lookup_pkg::lookup_id})
                  && (beat.hdr.flag == lookup_pkg::ctrl_flag);

    // payload arrives little endian, table entries are big endian
    always_comb begin
        for (int i = 0; i < lookup_pkg::cdata_w / 8; i++) begin
            swapped[8*i +: 8] = beat.raw[lookup_pkg::cdata_w - 8 - 8*i +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= lookup_pkg::ps_idle;
            index      <= '0;
            c_m_tdata  <= '0;
            c_m_tvalid <= 1'b0;
            c_m_tlast  <= 1'b0;
            wr.cam_we  <= 1'b0;
            wr.act_we  <= 1'b0;
        end else begin
            // strobes default low, raised only by an accepted beat
            c_m_tvalid <= 1'b0;
            c_m_tlast  <= 1'b0;
            wr.cam_we  <= 1'b0;
            wr.act_we  <= 1'b0;

            case (state)
                lookup_pkg::ps_idle: begin
                    if (c_s_tvalid) begin
                        if (hdr_hit) begin
                            index <= beat.hdr.index[lookup_pkg::tbl_addr_w-1:0];
                            // a header-only packet writes nothing
                            if (!c_s_tlast) begin
                                if (beat.hdr.resv == 4'd0) begin
                                    state <= lookup_pkg::ps_cam;
                                end else begin
                                    state <= lookup_pkg::ps_act;
                                end
                            end
                        end else begin
                            c_m_tdata  <= c_s_tdata;
                            c_m_tvalid <= 1'b1;
                            c_m_tlast  <= c_s_tlast;
                            if (!c_s_tlast) begin
                                state <= lookup_pkg::ps_fwd;
                            end
                        end
                    end
                end

                lookup_pkg::ps_cam,
                lookup_pkg::ps_act: begin
                    if (c_s_tvalid) begin
                        wr.cam_we <= (state == lookup_pkg::ps_cam);
                        wr.act_we <= (state == lookup_pkg::ps_act);
                        // 4-bit index wraps from 15 to 0
                        index <= index + 1'b1;
                        if (c_s_tlast) begin
                            state <= lookup_pkg::ps_idle;
                        end
                    end
                end

                lookup_pkg::ps_fwd: begin
                    if (c_s_tvalid) begin
                        c_m_tdata  <= c_s_tdata;
                        c_m_tvalid <= 1'b1;
                        c_m_tlast  <= c_s_tlast;
                        if (c_s_tlast) begin
                            state <= lookup_pkg::ps_idle;
                        end
                    end
                end

                default: begin
                    state <= lookup_pkg::ps_idle;
                end
            endcase
        end
    end

    // entry address and data line up with the write pulse
    always_ff @(posedge clk) begin
        wr.cam_addr <= index;
        wr.act_addr <= index;
        wr.cam_data <= swapped[lookup_pkg::cdata_w-1 -: lookup_pkg::key_w];
        wr.act_data <= swapped[lookup_pkg::cdata_w-1 -: lookup_pkg::act_w];
    end

endmodule

//--- src/lookup_engine.sv
`timescale 1ns/1ps

module lookup_engine (
    input  logic                           clk,
    input  logic                           rst_n,

    // from the key extractor
    input  logic [lookup_pkg::key_w-1:0]   key,
    input  logic [lookup_pkg::key_w-1:0]   mask,
    input  logic                           key_valid,
    input  logic [lookup_pkg::phv_w-1:0]   phv_in,

    // to the action engine
    output logic [lookup_pkg::act_w-1:0]   action,
    output logic                           action_valid,
    output logic [lookup_pkg::phv_w-1:0]   phv_out,

    // control stream in
    input  logic [lookup_pkg::cdata_w-1:0] c_s_tdata,
    input  logic                           c_s_tvalid,
    input  logic                           c_s_tlast,

    // control stream out
    output logic [lookup_pkg::cdata_w-1:0] c_m_tdata,
    output logic                           c_m_tvalid,
    output logic                           c_m_tlast
);

    logic                              match;
    logic [lookup_pkg::tbl_addr_w-1:0] match_addr;
    logic [lookup_pkg::act_w-1:0]      action_rdata;

    table_wr_if wr_bus ();

    ctrl_parser u_ctrl_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .c_s_tdata  (c_s_tdata),
        .c_s_tvalid (c_s_tvalid),
        .c_s_tlast  (c_s_tlast),
        .c_m_tdata  (c_m_tdata),
        .c_m_tvalid (c_m_tvalid),
        .c_m_tlast  (c_m_tlast),
        .wr         (wr_bus.master)
    );

    tcam u_tcam (
        .clk        (clk),
        .rst_n      (rst_n),
        .key        (key),
        .mask       (mask),
        .wr         (wr_bus.cam),
        .match      (match),
        .match_addr (match_addr)
    );

    action_ram u_action_ram (
        .clk          (clk),
        .wr           (wr_bus.act),
        .match_addr   (match_addr),
        .action_rdata (action_rdata)
    );

    lookup_fsm u_lookup_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .match        (match),
        .action_rdata (action_rdata),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out)
    );

endmodule

//--- src/lookup_fsm.sv
`timescale 1ns/1ps

module lookup_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         key_valid,
    input  logic [lookup_pkg::phv_w-1:0] phv_in,
    input  logic                         match,
    input  logic [lookup_pkg::act_w-1:0] action_rdata,
    output logic [lookup_pkg::act_w-1:0] action,
    output logic                         action_valid,
    output logic [lookup_pkg::phv_w-1:0] phv_out
);

    logic [1:0]                   state;
    logic [lookup_pkg::phv_w-1:0] phv_reg;

    always_ff @(posedge clk) begin
        if (state == lookup_pkg::ls_idle && key_valid) begin
            phv_reg <= phv_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= lookup_pkg::ls_idle;
            action       <= '0;
            action_valid <= 1'b0;
            phv_out      <= '0;
        end else begin
            case (state)
                lookup_pkg::ls_idle: begin
                    action_valid <= 1'b0;
                    if (key_valid) begin
                        state <= lookup_pkg::ls_check;
                    end
                end

                // tcam result for the captured key is ready here
                lookup_pkg::ls_check: begin
                    if (match) begin
                        state <= lookup_pkg::ls_wait;
                    end else begin
                        action       <= lookup_pkg::default_action;
                        action_valid <= 1'b1;
                        phv_out      <= phv_reg;
                        state        <= lookup_pkg::ls_idle;
                    end
                end

                // action ram output register fills
                lookup_pkg::ls_wait: begin
                    state <= lookup_pkg::ls_emit;
                end

                lookup_pkg::ls_emit: begin
                    action       <= action_rdata;
                    action_valid <= 1'b1;
                    phv_out      <= phv_reg;
                    state        <= lookup_pkg::ls_idle;
                end

                default: begin
                    state <= lookup_pkg::ls_idle;
                end
            endcase
        end
    end

endmodule

//--- src/lookup_pkg.sv
package lookup_pkg;

    // datapath widths
    localparam int key_w   = 32;
    localparam int phv_w   = 32;
    localparam int act_w   = 64;
    localparam int cdata_w = 64;

    // table geometry
    localparam int tbl_depth  = 16;
    localparam int tbl_addr_w = 4;

    // identity of this stage on the control stream
    localparam logic [4:0]  stage_id  = 5'd0;
    localparam logic [2:0]  lookup_id = 3'd2;
    localparam logic [15:0] ctrl_flag = 16'hf2f1;

    // action returned when no entry matches
    localparam logic [act_w-1:0] default_action = 64'h3f;

    // control parser states
    localparam logic [1:0] ps_idle = 2'd0;
    localparam logic [1:0] ps_cam  = 2'd1;
    localparam logic [1:0] ps_act  = 2'd2;
    localparam logic [1:0] ps_fwd  = 2'd3;

    // lookup sequencer states
    localparam logic [1:0] ls_idle  = 2'd0;
    localparam logic [1:0] ls_check = 2'd1;
    localparam logic [1:0] ls_wait  = 2'd2;
    localparam logic [1:0] ls_emit  = 2'd3;

    // header beat, msb first
    typedef struct packed {
        logic [7:0]  mod_id;
        logic [3:0]  resv;
        logic [7:0]  index;
        logic [27:0] unused;
        logic [15:0] flag;
    } ctrl_hdr_t;

    // a control beat is either a header or a raw payload word
    typedef union packed {
        ctrl_hdr_t          hdr;
        logic [cdata_w-1:0] raw;
    } ctrl_beat_u;

endpackage

//--- src/table_wr_if.sv
`timescale 1ns/1ps

interface table_wr_if;

    // cam entry write
    logic                              cam_we;
    logic [lookup_pkg::tbl_addr_w-1:0] cam_addr;
    logic [lookup_pkg::key_w-1:0]      cam_data;

    // action entry write
    logic                              act_we;
    logic [lookup_pkg::tbl_addr_w-1:0] act_addr;
    logic [lookup_pkg::act_w-1:0]      act_data;

    modport master (
        output cam_we, cam_addr, cam_data,
        output act_we, act_addr, act_data
    );

    modport cam (input cam_we, cam_addr, cam_data);

    modport act (input act_we, act_addr, act_data);

endinterface

//--- src/tcam.sv
`timescale 1ns/1ps

module tcam (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [lookup_pkg::key_w-1:0]      key,
    input  logic [lookup_pkg::key_w-1:0]      mask,
    table_wr_if.cam                           wr,
    output logic                              match,
    output logic [lookup_pkg::tbl_addr_w-1:0] match_addr
);

    logic [lookup_pkg::key_w-1:0]      keys [lookup_pkg::tbl_depth];
    logic [lookup_pkg::tbl_depth-1:0]  entry_valid;
    logic [lookup_pkg::tbl_depth-1:0]  hit_vec;
    logic [lookup_pkg::tbl_addr_w-1:0] first_hit;

    always_ff @(posedge clk) begin
        if (wr.cam_we) begin
            keys[wr.cam_addr] <= wr.cam_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (wr.cam_we) begin
            entry_valid[wr.cam_addr] <= 1'b1;
        end
    end

    // a set mask bit is don't care
    always_comb begin
        for (int i = 0; i < lookup_pkg::tbl_depth; i++) begin
            hit_vec[i] = entry_valid[i] && (((keys[i] ^ key) & ~mask) == '0);
        end
    end

    // lowest index wins, so scan from the top down
    always_comb begin
        first_hit = '0;
        for (int i = lookup_pkg::tbl_depth - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                first_hit = lookup_pkg::tbl_addr_w'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match      <= 1'b0;
            match_addr <= '0;
        end else begin
            match      <= |hit_vec;
            match_addr <= first_hit;
        end
    end

endmodule

//--- tb.f
src/lookup_pkg.sv
src/table_wr_if.sv
src/ctrl_parser.sv
src/tcam.sv
src/action_ram.sv
src/lookup_fsm.sv
src/lookup_engine.sv
test/lookup_engine_sva.sv
test/tb_lookup_engine.sv

//--- test/lookup_engine_sva.sv
`timescale 1ns/1ps

module lookup_engine_sva (
    input logic                           clk,
    input logic                           rst_n,
    input logic                           key_valid,
    input logic                           action_valid,
    input logic [lookup_pkg::cdata_w-1:0] c_s_tdata,
    input logic                           c_s_tvalid,
    input logic                           c_s_tlast,
    input logic                           c_m_tvalid
);

    logic       in_pkt;
    logic       own_pkt;
    logic       hdr_own;
    logic       busy;
    logic       start;
    logic [2:0] age;

    // header addressed to this stage with the table-write flag
    assign hdr_own = (c_s_tdata[63:56] == {lookup_pkg::stage_id, lookup_pkg::lookup_id})
                  && (c_s_tdata[15:0] == lookup_pkg::ctrl_flag);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt  <= 1'b0;
            own_pkt <= 1'b0;
        end else if (c_s_tvalid) begin
            in_pkt <= !c_s_tlast;
            if (!in_pkt) begin
                own_pkt <= hdr_own;
            end
        end
    end

    // the sequencer is idle again in the cycle that shows action_valid
    assign start = key_valid && (!busy || action_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            age  <= 3'd0;
        end else if (start) begin
            busy <= 1'b1;
            age  <= 3'd1;
        end else begin
            if (action_valid) begin
                busy <= 1'b0;
            end
            if (busy && age != 3'd7) begin
                age <= age + 3'd1;
            end
        end
    end

    single_cycle_valid: assert property (
        @(posedge clk) disable iff (!rst_n) action_valid |=> !action_valid
    ) else $error("action_valid held for two cycles");

    no_fwd_on_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        c_s_tvalid && (in_pkt ? own_pkt : hdr_own) |=> !c_m_tvalid
    ) else $error("c_m_tvalid raised by a table-write packet");

    valid_in_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        action_valid |-> busy && age >= 3'd2 && age <= 3'd4
    ) else $error("action_valid outside 2 to 4 cycles after key_valid");

    valid_not_late: assert property (
        @(posedge clk) disable iff (!rst_n) busy |-> age <= 3'd4
    ) else $error("action_valid missing 4 cycles after key_valid");

endmodule

bind lookup_engine lookup_engine_sva i_sva (
    .clk          (clk),
    .rst_n        (rst_n),
    .key_valid    (key_valid),
    .action_valid (action_valid),
    .c_s_tdata    (c_s_tdata),
    .c_s_tvalid   (c_s_tvalid),
    .c_s_tlast    (c_s_tlast),
    .c_m_tvalid   (c_m_tvalid)
);

//--- test/tb_lookup_engine.sv
`timescale 1ns/1ps

module tb_lookup_engine;

    typedef enum int {op_cam, op_act, op_fwd, op_look} op_e;

    // one stimulus row
    // op selects the packet fields or the lookup fields
    typedef struct {
        op_e         op;
        logic [7:0]  mod_id;
        logic [3:0]  resv;
        logic [7:0]  index;
        logic [15:0] flag;
        int          beats;
        int          key_idx;
        logic [31:0] key_flip;
        logic [31:0] mask;
        int          mask_idx;
        int          exp_idx;
    } row_t;

    logic                           clk;
    logic                           rst_n;
    logic [lookup_pkg::key_w-1:0]   key;
    logic [lookup_pkg::key_w-1:0]   mask;
    logic                           key_valid;
    logic [lookup_pkg::phv_w-1:0]   phv_in;
    logic [lookup_pkg::act_w-1:0]   action;
    logic                           action_valid;
    logic [lookup_pkg::phv_w-1:0]   phv_out;
    logic [lookup_pkg::cdata_w-1:0] c_s_tdata;
    logic                           c_s_tvalid;
    logic                           c_s_tlast;
    logic [lookup_pkg::cdata_w-1:0] c_m_tdata;
    logic                           c_m_tvalid;
    logic                           c_m_tlast;

    row_t        rows [$];
    logic [15:0] lfsr_state;
    logic [31:0] cam_model [16];
    logic [63:0] act_model [16];

    lookup_engine i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .key          (key),
        .mask         (mask),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out),
        .c_s_tdata    (c_s_tdata),
        .c_s_tvalid   (c_s_tvalid),
        .c_s_tlast    (c_s_tlast),
        .c_m_tdata    (c_m_tdata),
        .c_m_tvalid   (c_m_tvalid),
        .c_m_tlast    (c_m_tlast)
    );

    always #2 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [63:0] w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [63:0] byte_reverse(input logic [63:0] w);
        logic [63:0] r;
        for (int i = 0; i < 8; i++) begin
            r[8*i +: 8] = w[63 - 8*i -: 8];
        end
        return r;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("error: %s is 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // control output one cycle after a beat was accepted
    task automatic check_forward(input logic own, input logic [63:0] data, input logic last);
        if (own) begin
            check_value("c_m_tvalid", 64'(c_m_tvalid), 64'h0);
        end else begin
            check_value("c_m_tvalid", 64'(c_m_tvalid), 64'h1);
            check_value("c_m_tdata", c_m_tdata, data);
            check_value("c_m_tlast", 64'(c_m_tlast), 64'(last));
        end
    endtask

    task automatic send_packet(input row_t r);
        logic [63:0] beats_q [$];
        logic [63:0] w;
        logic [63:0] rev;
        logic        own;
        int          slot;
        int          n;
        own = (r.op != op_fwd);
        beats_q.push_back({r.mod_id, r.resv, r.index, 28'h0, r.flag});
        for (int b = 0; b < r.beats; b++) begin
            take_bits(64, w);
            beats_q.push_back(w);
            // payload is stored byte reversed
            rev  = byte_reverse(w);
            // index wraps at 16
            slot = (int'(r.index) + b) % 16;
            if (r.op == op_cam) begin
                cam_model[slot] = rev[63:32];
            end else if (r.op == op_act) begin
                act_model[slot] = rev;
            end
        end
        n = beats_q.size();
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_forward(own, beats_q[i-1], 1'b0);
            end
            c_s_tdata  = beats_q[i];
            c_s_tvalid = 1'b1;
            c_s_tlast  = (i == n - 1);
        end
        @(negedge clk);
        check_forward(own, beats_q[n-1], 1'b1);
        c_s_tdata  = '0;
        c_s_tvalid = 1'b0;
        c_s_tlast  = 1'b0;
        @(negedge clk);
        check_value("c_m_tvalid", 64'(c_m_tvalid), 64'h0);
    endtask

    task automatic do_lookup(input row_t r);
        logic [31:0] k;
        logic [31:0] m;
        logic [63:0] w;
        logic [63:0] exp_act;
        int          t;
        if (r.key_idx < 0) begin
            k = r.key_flip;
        end else begin
            k = cam_model[r.key_idx] ^ r.key_flip;
        end
        m = r.mask;
        // mask the bits where two entries differ so both match
        if (r.mask_idx >= 0) begin
            m = m | (cam_model[r.key_idx] ^ cam_model[r.mask_idx]);
        end
        exp_act = (r.exp_idx < 0) ? 64'h3f : act_model[r.exp_idx];
        take_bits(32, w);
        @(negedge clk);
        key       = k;
        mask      = m;
        phv_in    = w[31:0];
        key_valid = 1'b1;
        @(negedge clk);
        key_valid = 1'b0;
        t = 0;
        while (!action_valid) begin
            if (t == 20) begin
                fail_run("timeout: action_valid did not rise within 20 cycles");
            end
            @(negedge clk);
            t++;
        end
        // a miss answers from check, a hit passes through wait and emit
        check_value("action_valid latency", 64'(t), (r.exp_idx < 0) ? 64'd1 : 64'd3);
        check_value("action", action, exp_act);
        check_value("phv_out", 64'(phv_out), 64'(w[31:0]));
        @(negedge clk);
        check_value("action_valid", 64'(action_valid), 64'h0);
    endtask

    task automatic build_table();
        // op, mod_id, resv, index, flag, beats, key_idx, key_flip, mask, mask_idx, exp_idx
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, -1, 32'h1234_5678,
                         32'h0, -1, -1});
        rows.push_back('{op_cam,  8'h02, 4'h0, 8'h05, 16'hf2f1, 1, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_act,  8'h02, 4'h1, 8'h05, 16'hf2f1, 1, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 5, 32'h0, 32'h0, -1, 5});
        rows.push_back('{op_cam,  8'h02, 4'h0, 8'h08, 16'hf2f1, 4, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_act,  8'h02, 4'h3, 8'h08, 16'hf2f1, 4, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_cam,  8'h02, 4'h0, 8'h0f, 16'hf2f1, 3, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_act,  8'h02, 4'hf, 8'h0f, 16'hf2f1, 3, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 8, 32'h0, 32'h0, -1, 8});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 9, 32'h0, 32'h0, -1, 9});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 10, 32'h0, 32'h0, -1, 10});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 11, 32'h0, 32'h0, -1, 11});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 15, 32'h0, 32'h0, -1, 15});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 0, 32'h0, 32'h0, -1, 0});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 1, 32'h0, 32'h0, -1, 1});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 9, 32'h00ff_0000,
                         32'h00ff_0000, -1, 9});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 10, 32'h0, 32'h0, 1, 1});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 15, 32'h0, 32'h0, 8, 8});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 11, 32'h8000_0000,
                         32'h0000_ffff, -1, -1});
        rows.push_back('{op_fwd,  8'h02, 4'h0, 8'h03, 16'hf2f0, 2, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_fwd,  8'h0a, 4'h0, 8'h05, 16'hf2f1, 3, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_fwd,  8'h03, 4'h2, 8'h05, 16'hf2f1, 1, 0, 32'h0, 32'h0, -1, -1});
        rows.push_back('{op_look, 8'h00, 4'h0, 8'h00, 16'h0000, 0, 5, 32'h0, 32'h0, -1, 5});
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        key        = '0;
        mask       = '0;
        key_valid  = 1'b0;
        phv_in     = '0;
        c_s_tdata  = '0;
        c_s_tvalid = 1'b0;
        c_s_tlast  = 1'b0;
        lfsr_state = 16'd53387;
        build_table();

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // everything idle before the first lookup
        check_value("action_valid", 64'(action_valid), 64'h0);
        check_value("action", action, 64'h0);
        check_value("phv_out", 64'(phv_out), 64'h0);
        check_value("c_m_tvalid", 64'(c_m_tvalid), 64'h0);
        check_value("c_m_tlast", 64'(c_m_tlast), 64'h0);
        check_value("c_m_tdata", c_m_tdata, 64'h0);

        foreach (rows[i]) begin
            if (rows[i].op == op_look) begin
                do_lookup(rows[i]);
            end else begin
                send_packet(rows[i]);
            end
            repeat (2) @(negedge clk);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
